// File: sec_mem_subsys.f
design/sec_mem_pkg.sv
design/line_mem.sv
design/partition_check.sv
design/mem_arbiter.sv
design/dma_line_counter.sv
design/dma_ctrl_fsm.sv
design/sec_mem_subsys.sv
sim/sec_mem_subsys_sva.sv
sim/tb_sec_mem_subsys.sv

// File: sim/sec_mem_golden.txt
# W addr domain data opaque fail | R addr domain opaque data fail
# S src dest nlines domain | D fail | C
C
W 00000040 1 0123456789abcdeffedcba9876543210 01 0
W 00000050 1 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 02 0
R 00000040 1 03 0123456789abcdeffedcba9876543210 0
W 00000900 1 deadbeef00000000cafef00d11111111 04 0
W 00000900 0 ffffffffffffffffffffffffffffffff 05 1
R 00000900 0 06 0 1
R 00000900 1 07 deadbeef00000000cafef00d11111111 0
S 00000040 00000300 02 1
D 0
R 00000300 1 08 0123456789abcdeffedcba9876543210 0
R 00000310 1 09 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 0
W 000007e0 0 13579bdf2468ace013579bdf2468ace0 0a 0
S 000007e0 00000500 04 0
D 1
R 00000500 1 0b 13579bdf2468ace013579bdf2468ace0 0
R 00000520 1 0c 0 0
S 00000040 00000c00 08 1
R 00000900 1 0d deadbeef00000000cafef00d11111111 0
R 00000300 1 0e 0123456789abcdeffedcba9876543210 0
D 0
R 00000c00 1 0f 0123456789abcdeffedcba9876543210 0
R 00000c10 1 10 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 0
C
R 00000040 1 11 0 0
R 00000900 1 12 0 0

// File: sim/tb_sec_mem_subsys.sv
/*
 * testbench for the secure memory subsystem
 * golden-file stimulus, random response back-pressure, timeout
 */

`timescale 1ns/1ps

module tb_sec_mem_subsys;

	import sec_mem_pkg::*;

	typedef struct packed {
		logic [7:0]          kind;
		logic [ADDR_W-1:0]   addr;
		logic [ADDR_W-1:0]   dest;
		logic [DATA_W-1:0]   data;
		logic [OPAQUE_W-1:0] opaque;
		logic [NLINES_W-1:0] nlines;
		logic                domain;
		logic                fail;
	} golden_rec_t;

	logic        clk;
	logic        arst_n;
	logic        mem_clear;
	mem_req_t    refill_req;
	logic        refill_req_val;
	logic        refill_req_rdy;
	mem_resp_t   refill_resp;
	logic        refill_resp_val;
	logic        refill_resp_rdy;
	dma_cmd_t    dma_cmd;
	logic        dma_cmd_val;
	logic        dma_cmd_rdy;
	logic        dma_done;
	logic        dma_fail;

	golden_rec_t recs[$];
	logic [31:0] lfsr;
	int          err_data;
	int          err_flag;
	int          err_dma;
	int          cycles;
	int          cycle_limit;
	int          done_count;
	int          done_checked;
	logic        last_fail;

	sec_mem_subsys u_sec_mem_subsys (
		.clk             (clk),
		.arst_n          (arst_n),
		.mem_clear       (mem_clear),
		.refill_req      (refill_req),
		.refill_req_val  (refill_req_val),
		.refill_req_rdy  (refill_req_rdy),
		.refill_resp     (refill_resp),
		.refill_resp_val (refill_resp_val),
		.refill_resp_rdy (refill_resp_rdy),
		.dma_cmd         (dma_cmd),
		.dma_cmd_val     (dma_cmd_val),
		.dma_cmd_rdy     (dma_cmd_rdy),
		.dma_done        (dma_done),
		.dma_fail        (dma_fail)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	//======================================================================
	// clock, back-pressure, watchdog, DMA done monitor
	//======================================================================

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// one bit per cycle
	always @(posedge clk) begin
		#5;
		lfsr = lfsr_next(lfsr);
		refill_resp_rdy = lfsr[0];
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout waiting for response");
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (arst_n && dma_done) begin
			done_count++;
			last_fail = dma_fail;
		end
	end

	//======================================================================
	// golden file and record tasks
	//======================================================================

	task automatic read_golden(output int count);
		int                  fd;
		int                  n;
		bit                  bad;
		logic [63:0]         kind_s;
		logic [8*256-1:0]    skip_line;
		logic [ADDR_W-1:0]   a;
		logic [ADDR_W-1:0]   b;
		logic [DATA_W-1:0]   d;
		logic [OPAQUE_W-1:0] o;
		logic [NLINES_W-1:0] nl;
		logic                dm;
		logic                fl;
		golden_rec_t         r;
		bad = 1'b0;
		fd = $fopen("sim/sec_mem_golden.txt", "r");
		if (fd == 0) begin
			count = -1;
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", kind_s);
				if (n == 1) begin
					r = '0;
					r.kind = kind_s[7:0];
					case (kind_s)
						"#": n = $fgets(skip_line, fd);
						"W": begin
							n = $fscanf(fd, "%h %h %h %h %h", a, dm, d, o, fl);
							r.addr = a;
							r.domain = dm;
							r.data = d;
							r.opaque = o;
							r.fail = fl;
							recs.push_back(r);
						end
						"R": begin
							n = $fscanf(fd, "%h %h %h %h %h", a, dm, o, d, fl);
							r.addr = a;
							r.domain = dm;
							r.opaque = o;
							r.data = d;
							r.fail = fl;
							recs.push_back(r);
						end
						"S": begin
							n = $fscanf(fd, "%h %h %h %h", a, b, nl, dm);
							r.addr = a;
							r.dest = b;
							r.nlines = nl;
							r.domain = dm;
							recs.push_back(r);
						end
						"D": begin
							n = $fscanf(fd, "%h", fl);
							r.fail = fl;
							recs.push_back(r);
						end
						"C": recs.push_back(r);
						default: begin
							$display("unknown record kind %s in golden file", kind_s);
							bad = 1'b1;
						end
					endcase
				end
			end
			$fclose(fd);
			count = bad ? -1 : recs.size();
		end
	endtask

	task automatic refill_access(input golden_rec_t r, input int idx);
		mem_resp_t         resp;
		mem_op_e           exp_op;
		logic [DATA_W-1:0] exp_data;
		string             name;
		exp_op = (r.kind == "W") ? MEM_WRITE : MEM_READ;
		exp_data = (r.kind == "W") ? '0 : r.data;
		name = $sformatf("rec%0d %s %h", idx, (r.kind == "W") ? "write" : "read", r.addr);
		@(posedge clk);
		#5;
		refill_req.op = exp_op;
		refill_req.opaque = r.opaque;
		refill_req.addr = r.addr;
		refill_req.data = (r.kind == "W") ? r.data : '0;
		refill_req.domain = r.domain;
		refill_req_val = 1'b1;
		@(negedge clk);
		while (!refill_req_rdy)
			@(negedge clk);
		@(posedge clk);
		#5;
		refill_req_val = 1'b0;
		@(negedge clk);
		while (!(refill_resp_val && refill_resp_rdy))
			@(negedge clk);
		resp = refill_resp;
		if (resp.fail !== r.fail) begin
			$display("ERROR %s fail: expected %0b, actual %0b", name, r.fail, resp.fail);
			err_flag++;
		end
		if (resp.opaque !== r.opaque) begin
			$display("ERROR %s opaque: expected %h, actual %h", name, r.opaque, resp.opaque);
			err_flag++;
		end
		if (resp.op !== exp_op) begin
			$display("ERROR %s op: expected %0d, actual %0d", name, exp_op, resp.op);
			err_flag++;
		end
		if (resp.data !== exp_data) begin
			$display("ERROR %s data: expected %h, actual %h", name, exp_data, resp.data);
			err_data++;
		end
	endtask

	task automatic start_dma(input golden_rec_t r);
		@(posedge clk);
		#5;
		dma_cmd.src = r.addr;
		dma_cmd.dest = r.dest;
		dma_cmd.nlines = r.nlines;
		dma_cmd.domain = r.domain;
		dma_cmd_val = 1'b1;
		@(negedge clk);
		while (!dma_cmd_rdy)
			@(negedge clk);
		@(posedge clk);
		#5;
		dma_cmd_val = 1'b0;
	endtask

	task automatic wait_dma(input golden_rec_t r, input int idx);
		while (done_count == done_checked)
			@(posedge clk);
		done_checked++;
		if (last_fail !== r.fail) begin
			$display("ERROR rec%0d dma wait: expected fail %0b, actual %0b",
				idx, r.fail, last_fail);
			err_dma++;
		end
	endtask

	task automatic clear_memory();
		@(posedge clk);
		#5;
		mem_clear = 1'b1;
		@(posedge clk);
		#5;
		mem_clear = 1'b0;
	endtask

	//======================================================================
	// main sequence
	//======================================================================

	initial begin
		int nrec;
		int i;
		int err_assert;
		arst_n = 1'b0;
		mem_clear = 1'b0;
		refill_req = '0;
		refill_req_val = 1'b0;
		refill_resp_rdy = 1'b0;
		dma_cmd = '0;
		dma_cmd_val = 1'b0;
		lfsr = 32'hf02e_df53;
		err_data = 0;
		err_flag = 0;
		err_dma = 0;
		cycles = 0;
		cycle_limit = 0;
		done_count = 0;
		done_checked = 0;
		last_fail = 1'b0;
		read_golden(nrec);
		if (nrec <= 0) begin
			$display("golden file sim/sec_mem_golden.txt is missing or unreadable");
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			cycle_limit = nrec * 64 + 32;
			repeat (16) @(posedge clk);
			#5;
			arst_n = 1'b1;
			for (i = 0; i < nrec; i++) begin
				case (recs[i].kind)
					"W", "R": refill_access(recs[i], i);
					"S":      start_dma(recs[i]);
					"D":      wait_dma(recs[i], i);
					default:  clear_memory();
				endcase
			end
			repeat (4) @(posedge clk);
			err_assert = u_sec_mem_subsys.u_sec_mem_subsys_sva.fail_count;
			$display("errors: %0d data, %0d status, %0d dma, %0d assertion",
				err_data, err_flag, err_dma, err_assert);
			if (err_data + err_flag + err_dma + err_assert == 0) begin
				$display("*** TEST PASSED ***");
			end else begin
				$display("*** TEST FAILED ***");
			end
			$finish;
		end
	end

endmodule

// File: sim/sec_mem_subsys_sva.sv
/*
 * bound assertions on the subsystem ports
 */

`timescale 1ns/1ps

module sec_mem_subsys_sva (
	input logic                   clk,
	input logic                   arst_n,
	input sec_mem_pkg::mem_resp_t refill_resp,
	input logic                   refill_resp_val,
	input logic                   refill_resp_rdy,
	input logic                   dma_cmd_val,
	input logic                   dma_cmd_rdy,
	input logic                   dma_done
);

	logic dma_busy;
	int   fail_count = 0;

	// a job is running from command transfer until its done pulse
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			dma_busy <= 1'b0;
		else if (dma_cmd_val && dma_cmd_rdy)
			dma_busy <= 1'b1;
		else if (dma_done)
			dma_busy <= 1'b0;
	end

	resp_held: assert property (@(posedge clk) disable iff (!arst_n)
		refill_resp_val && !refill_resp_rdy |=> refill_resp_val && $stable(refill_resp))
		else begin
			$error("refill response dropped or changed before it was taken");
			fail_count++;
		end

	done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		dma_done |=> !dma_done)
		else begin
			$error("dma_done held for more than one cycle");
			fail_count++;
		end

	no_cmd_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
		dma_busy |-> !dma_cmd_rdy)
		else begin
			$error("dma_cmd_rdy high while a DMA job is running");
			fail_count++;
		end

endmodule

bind sec_mem_subsys sec_mem_subsys_sva u_sec_mem_subsys_sva (
	.clk             (clk),
	.arst_n          (arst_n),
	.refill_resp     (refill_resp),
	.refill_resp_val (refill_resp_val),
	.refill_resp_rdy (refill_resp_rdy),
	.dma_cmd_val     (dma_cmd_val),
	.dma_cmd_rdy     (dma_cmd_rdy),
	.dma_done        (dma_done)
);

// File: design/sec_mem_subsys.sv
/*
 * data-side secure memory subsystem top level
 * refill port and DMA engine share one checked line memory
 */

`timescale 1ns/1ps

module sec_mem_subsys #(
	parameter int                           p_mem_nlines     = 256,
	parameter logic [sec_mem_pkg::ADDR_W-1:0] p_partition_addr = 32'h0000_0800
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   mem_clear,

	input  sec_mem_pkg::mem_req_t  refill_req,
	input  logic                   refill_req_val,
	output logic                   refill_req_rdy,
	output sec_mem_pkg::mem_resp_t refill_resp,
	output logic                   refill_resp_val,
	input  logic                   refill_resp_rdy,

	input  sec_mem_pkg::dma_cmd_t  dma_cmd,
	input  logic                   dma_cmd_val,
	output logic                   dma_cmd_rdy,
	output logic                   dma_done,
	output logic                   dma_fail
);

	import sec_mem_pkg::*;

	// DMA to arbiter
	mem_req_t  dma_req;
	logic      dma_req_val;
	logic      dma_req_rdy;
	mem_resp_t dma_resp;
	logic      dma_resp_val;
	logic      dma_resp_rdy;

	// arbiter to partition check
	mem_req_t  arb_req;
	logic      arb_req_val;
	logic      arb_req_rdy;
	mem_resp_t arb_resp;
	logic      arb_resp_val;
	logic      arb_resp_rdy;

	// partition check to memory
	mem_req_t  chk_req;
	logic      chk_req_val;
	logic      chk_req_rdy;
	mem_resp_t chk_resp;
	logic      chk_resp_val;
	logic      chk_resp_rdy;

	logic              cnt_load;
	logic              cnt_step;
	logic [ADDR_W-1:0] cnt_src;
	logic [ADDR_W-1:0] cnt_dest;
	logic              cnt_last;

	//======================================================================
	// DMA engine
	//======================================================================

	dma_ctrl_fsm u_dma_ctrl_fsm (
		.clk          (clk),
		.arst_n       (arst_n),
		.cmd          (dma_cmd),
		.cmd_val      (dma_cmd_val),
		.cmd_rdy      (dma_cmd_rdy),
		.cnt_load     (cnt_load),
		.cnt_step     (cnt_step),
		.cur_src      (cnt_src),
		.cur_dest     (cnt_dest),
		.last         (cnt_last),
		.mem_req      (dma_req),
		.mem_req_val  (dma_req_val),
		.mem_req_rdy  (dma_req_rdy),
		.mem_resp     (dma_resp),
		.mem_resp_val (dma_resp_val),
		.mem_resp_rdy (dma_resp_rdy),
		.done         (dma_done),
		.fail         (dma_fail)
	);

	// zero-length jobs are caught by the FSM from the command itself
	dma_line_counter u_dma_line_counter (
		.clk       (clk),
		.arst_n    (arst_n),
		.load      (cnt_load),
		.step      (cnt_step),
		.src_in    (dma_cmd.src),
		.dest_in   (dma_cmd.dest),
		.nlines_in (dma_cmd.nlines),
		.cur_src   (cnt_src),
		.cur_dest  (cnt_dest),
		.last      (cnt_last),
		.empty     ()
	);

	//======================================================================
	// shared memory path
	//======================================================================

	mem_arbiter u_mem_arbiter (
		.clk       (clk),
		.arst_n    (arst_n),
		.req0      (refill_req),
		.req0_val  (refill_req_val),
		.req0_rdy  (refill_req_rdy),
		.resp0     (refill_resp),
		.resp0_val (refill_resp_val),
		.resp0_rdy (refill_resp_rdy),
		.req1      (dma_req),
		.req1_val  (dma_req_val),
		.req1_rdy  (dma_req_rdy),
		.resp1     (dma_resp),
		.resp1_val (dma_resp_val),
		.resp1_rdy (dma_resp_rdy),
		.req       (arb_req),
		.req_val   (arb_req_val),
		.req_rdy   (arb_req_rdy),
		.resp      (arb_resp),
		.resp_val  (arb_resp_val),
		.resp_rdy  (arb_resp_rdy)
	);

	partition_check #(
		.p_partition_addr (p_partition_addr)
	) u_partition_check (
		.clk          (clk),
		.arst_n       (arst_n),
		.in_req       (arb_req),
		.in_req_val   (arb_req_val),
		.in_req_rdy   (arb_req_rdy),
		.in_resp      (arb_resp),
		.in_resp_val  (arb_resp_val),
		.in_resp_rdy  (arb_resp_rdy),
		.mem_req      (chk_req),
		.mem_req_val  (chk_req_val),
		.mem_req_rdy  (chk_req_rdy),
		.mem_resp     (chk_resp),
		.mem_resp_val (chk_resp_val),
		.mem_resp_rdy (chk_resp_rdy)
	);

	line_mem #(
		.p_mem_nlines (p_mem_nlines)
	) u_line_mem (
		.clk       (clk),
		.arst_n    (arst_n),
		.mem_clear (mem_clear),
		.req       (chk_req),
		.req_val   (chk_req_val),
		.req_rdy   (chk_req_rdy),
		.resp      (chk_resp),
		.resp_val  (chk_resp_val),
		.resp_rdy  (chk_resp_rdy)
	);

endmodule

// File: design/dma_ctrl_fsm.sv
/*
 * DMA control FSM
 * copies one line at a time as a read followed by a write
 */

`timescale 1ns/1ps

module dma_ctrl_fsm (
	input  logic                              clk,
	input  logic                              arst_n,

	input  sec_mem_pkg::dma_cmd_t             cmd,
	input  logic                              cmd_val,
	output logic                              cmd_rdy,

	output logic                              cnt_load,
	output logic                              cnt_step,
	input  logic [sec_mem_pkg::ADDR_W-1:0]    cur_src,
	input  logic [sec_mem_pkg::ADDR_W-1:0]    cur_dest,
	input  logic                              last,

	output sec_mem_pkg::mem_req_t             mem_req,
	output logic                              mem_req_val,
	input  logic                              mem_req_rdy,
	input  sec_mem_pkg::mem_resp_t            mem_resp,
	input  logic                              mem_resp_val,
	output logic                              mem_resp_rdy,

	output logic                              done,
	output logic                              fail
);

	import sec_mem_pkg::*;

	localparam logic [OPAQUE_W-1:0] DMA_OPAQUE = 'hd0;

	dma_state_e        state;
	dma_state_e        state_nxt;
	logic              fail_r;
	logic              domain_r;
	logic [DATA_W-1:0] line_buf;
	logic              cmd_fire;
	logic              resp_fire;

	assign cmd_rdy      = (state == DMA_IDLE);
	assign cmd_fire     = cmd_val && cmd_rdy;
	assign cnt_load     = cmd_fire;
	assign mem_req_val  = (state == DMA_RD_REQ) || (state == DMA_WR_REQ);
	assign mem_resp_rdy = (state == DMA_RD_WAIT) || (state == DMA_WR_WAIT);
	assign resp_fire    = mem_resp_val && mem_resp_rdy;
	assign cnt_step     = (state == DMA_WR_WAIT) && resp_fire && !mem_resp.fail && !last;
	assign done         = (state == DMA_DONE);
	assign fail         = done && fail_r;

	// read from src, write to dest
	always_comb begin
		mem_req        = '0;
		mem_req.opaque = DMA_OPAQUE;
		mem_req.domain = domain_r;
		if (state == DMA_WR_REQ) begin
			mem_req.op   = MEM_WRITE;
			mem_req.addr = cur_dest;
			mem_req.data = line_buf;
		end else begin
			mem_req.op   = MEM_READ;
			mem_req.addr = cur_src;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			DMA_IDLE:    if (cmd_fire) state_nxt = (cmd.nlines == '0) ? DMA_DONE : DMA_RD_REQ;
			DMA_RD_REQ:  if (mem_req_rdy) state_nxt = DMA_RD_WAIT;
			DMA_RD_WAIT: if (resp_fire) state_nxt = mem_resp.fail ? DMA_DONE : DMA_WR_REQ;
			DMA_WR_REQ:  if (mem_req_rdy) state_nxt = DMA_WR_WAIT;
			DMA_WR_WAIT: if (resp_fire) state_nxt = (mem_resp.fail || last) ? DMA_DONE : DMA_RD_REQ;
			default:     state_nxt = DMA_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= DMA_IDLE;
			fail_r <= 1'b0;
		end else begin
			state <= state_nxt;
			if (cmd_fire)
				fail_r <= 1'b0;
			else if (resp_fire && mem_resp.fail)
				fail_r <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_fire)
			domain_r <= cmd.domain;
		if (state == DMA_RD_WAIT && resp_fire)
			line_buf <= mem_resp.data;
	end

endmodule

// File: design/dma_line_counter.sv
/*
 * DMA address stepper and remaining-line counter
 */

`timescale 1ns/1ps

module dma_line_counter (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             load,
	input  logic                             step,
	input  logic [sec_mem_pkg::ADDR_W-1:0]   src_in,
	input  logic [sec_mem_pkg::ADDR_W-1:0]   dest_in,
	input  logic [sec_mem_pkg::NLINES_W-1:0] nlines_in,
	output logic [sec_mem_pkg::ADDR_W-1:0]   cur_src,
	output logic [sec_mem_pkg::ADDR_W-1:0]   cur_dest,
	output logic                             last,
	output logic                             empty
);

	import sec_mem_pkg::*;

	logic [NLINES_W-1:0] count;

	assign last  = (count == NLINES_W'(1));
	assign empty = (count == '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			count <= '0;
		else if (load)
			count <= nlines_in;
		else if (step && !empty)
			count <= count - 1'b1;
	end

	// one line per step
	always_ff @(posedge clk) begin
		if (load) begin
			cur_src  <= src_in;
			cur_dest <= dest_in;
		end else if (step) begin
			cur_src  <= cur_src + ADDR_W'(LINE_BYTES);
			cur_dest <= cur_dest + ADDR_W'(LINE_BYTES);
		end
	end

endmodule

// File: design/mem_arbiter.sv
/*
 * two-requester memory arbiter, requester 0 first
 * one access in flight, response steered back to its owner
 */

`timescale 1ns/1ps

module mem_arbiter (
	input  logic                   clk,
	input  logic                   arst_n,

	input  sec_mem_pkg::mem_req_t  req0,
	input  logic                   req0_val,
	output logic                   req0_rdy,
	output sec_mem_pkg::mem_resp_t resp0,
	output logic                   resp0_val,
	input  logic                   resp0_rdy,

	input  sec_mem_pkg::mem_req_t  req1,
	input  logic                   req1_val,
	output logic                   req1_rdy,
	output sec_mem_pkg::mem_resp_t resp1,
	output logic                   resp1_val,
	input  logic                   resp1_rdy,

	output sec_mem_pkg::mem_req_t  req,
	output logic                   req_val,
	input  logic                   req_rdy,
	input  sec_mem_pkg::mem_resp_t resp,
	input  logic                   resp_val,
	output logic                   resp_rdy
);

	import sec_mem_pkg::*;

	logic busy;
	logic owner;
	logic sel;

	// fixed priority while free
	assign sel      = !req0_val;
	assign req      = sel ? req1 : req0;
	assign req_val  = !busy && (req0_val || req1_val);
	assign req0_rdy = !busy && req_rdy;
	assign req1_rdy = !busy && !req0_val && req_rdy;

	assign resp0     = resp;
	assign resp1     = resp;
	assign resp0_val = busy && !owner && resp_val;
	assign resp1_val = busy && owner && resp_val;
	assign resp_rdy  = busy && (owner ? resp1_rdy : resp0_rdy);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy  <= 1'b0;
			owner <= 1'b0;
		end else if (req_val && req_rdy) begin
			busy  <= 1'b1;
			owner <= sel;
		end else if (resp_val && resp_rdy) begin
			busy <= 1'b0;
		end
	end

endmodule

// File: design/partition_check.sv
/*
 * domain-versus-partition access check
 * blocked requests are answered here with a fail response
 */

`timescale 1ns/1ps

module partition_check #(
	parameter logic [sec_mem_pkg::ADDR_W-1:0] p_partition_addr = 32'h0000_0800
) (
	input  logic                   clk,
	input  logic                   arst_n,

	input  sec_mem_pkg::mem_req_t  in_req,
	input  logic                   in_req_val,
	output logic                   in_req_rdy,
	output sec_mem_pkg::mem_resp_t in_resp,
	output logic                   in_resp_val,
	input  logic                   in_resp_rdy,

	output sec_mem_pkg::mem_req_t  mem_req,
	output logic                   mem_req_val,
	input  logic                   mem_req_rdy,
	input  sec_mem_pkg::mem_resp_t mem_resp,
	input  logic                   mem_resp_val,
	output logic                   mem_resp_rdy
);

	import sec_mem_pkg::*;

	mem_resp_t fail_resp;
	logic      fail_val;
	logic      blocked;
	logic      blk_fire;

	// insecure domain may not reach the upper partition
	assign blocked = !in_req.domain && (in_req.addr >= p_partition_addr);

	assign mem_req     = in_req;
	assign mem_req_val = in_req_val && !blocked && !fail_val;
	assign in_req_rdy  = !fail_val && (blocked || mem_req_rdy);
	assign blk_fire    = in_req_val && blocked && !fail_val;

	assign in_resp      = fail_val ? fail_resp : mem_resp;
	assign in_resp_val  = fail_val || mem_resp_val;
	assign mem_resp_rdy = in_resp_rdy && !fail_val;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			fail_val <= 1'b0;
		else if (blk_fire)
			fail_val <= 1'b1;
		else if (in_resp_rdy)
			fail_val <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (blk_fire) begin
			fail_resp.op     <= in_req.op;
			fail_resp.opaque <= in_req.opaque;
			fail_resp.data   <= '0;
			fail_resp.fail   <= 1'b1;
		end
	end

endmodule

// File: design/line_mem.sv
/*
 * line-wide main memory with registered response and bulk clear
 */

`timescale 1ns/1ps

module line_mem #(
	parameter int p_mem_nlines = 256
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   mem_clear,
	input  sec_mem_pkg::mem_req_t  req,
	input  logic                   req_val,
	output logic                   req_rdy,
	output sec_mem_pkg::mem_resp_t resp,
	output logic                   resp_val,
	input  logic                   resp_rdy
);

	import sec_mem_pkg::*;

	localparam int OFF_W = $clog2(LINE_BYTES);
	localparam int IDX_W = $clog2(p_mem_nlines);

	logic [DATA_W-1:0] mem [p_mem_nlines];
	logic [IDX_W-1:0]  idx;
	logic              req_fire;

	// line index wraps with memory size
	assign idx      = req.addr[OFF_W +: IDX_W];
	assign req_rdy  = !resp_val && !mem_clear;
	assign req_fire = req_val && req_rdy;

	always_ff @(posedge clk) begin
		if (mem_clear) begin
			for (int i = 0; i < p_mem_nlines; i++)
				mem[i] <= '0;
		end else if (req_fire && req.op == MEM_WRITE) begin
			mem[idx] <= req.data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			resp_val <= 1'b0;
		else if (req_fire)
			resp_val <= 1'b1;
		else if (resp_rdy)
			resp_val <= 1'b0;
	end

	// writes answer with zero data
	always_ff @(posedge clk) begin
		if (req_fire) begin
			resp.op     <= req.op;
			resp.opaque <= req.opaque;
			resp.data   <= (req.op == MEM_WRITE) ? '0 : mem[idx];
			resp.fail   <= 1'b0;
		end
	end

endmodule

// File: design/sec_mem_pkg.sv
/*
 * shared widths, opcodes and DMA states
 * request, response and DMA command structs
 */

package sec_mem_pkg;

	//======================================================================
	// widths
	//======================================================================

	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 128;
	localparam int OPAQUE_W   = 8;
	localparam int LINE_BYTES = 16;
	localparam int NLINES_W   = 8;

	//======================================================================
	// opcodes and states
	//======================================================================

	typedef enum logic [0:0] {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_op_e;

	typedef enum logic [2:0] {
		DMA_IDLE,
		DMA_RD_REQ,
		DMA_RD_WAIT,
		DMA_WR_REQ,
		DMA_WR_WAIT,
		DMA_DONE
	} dma_state_e;

	//======================================================================
	// channel payloads
	//======================================================================

	// domain 1 is secure
	typedef struct packed {
		mem_op_e             op;
		logic [OPAQUE_W-1:0] opaque;
		logic [ADDR_W-1:0]   addr;
		logic [DATA_W-1:0]   data;
		logic                domain;
	} mem_req_t;

	typedef struct packed {
		mem_op_e             op;
		logic [OPAQUE_W-1:0] opaque;
		logic [DATA_W-1:0]   data;
		logic                fail;
	} mem_resp_t;

	typedef struct packed {
		logic [ADDR_W-1:0]   src;
		logic [ADDR_W-1:0]   dest;
		logic [NLINES_W-1:0] nlines;
		logic                domain;
	} dma_cmd_t;

endpackage
